// File: hdl/stack_cpu_pkg.sv
package stack_cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_idx_t;

	//////////////////////////////////////////////////////////////////////
	// instruction fields
	//////////////////////////////////////////////////////////////////////

	// bits 15..12
	typedef enum logic [3:0] {
		OP_STACK     = 4'd0,
		OP_ALU       = 4'd1,
		OP_BR_ALWAYS = 4'd2,
		OP_BR_C      = 4'd3,
		OP_BR_NC     = 4'd4,
		OP_BR_Z      = 4'd5,
		OP_BR_NZ     = 4'd6,
		OP_BR_V      = 4'd7,
		OP_BR_NV     = 4'd8,
		OP_BR_S      = 4'd9,
		OP_BR_NS     = 4'd10,
		OP_CALL      = 4'd11,
		OP_RET       = 4'd12
	} opcode_t;

	// bits 11..10 of an alu instruction
	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_NEG = 2'd1,
		ALU_OR  = 2'd2,
		ALU_NOT = 2'd3
	} alu_fn_t;

	//////////////////////////////////////////////////////////////////////
	// sizes and reset values
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_REGS = 8;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int IMEM_AW = $clog2(IMEM_WORDS);
	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	localparam word_t PC_RESET = 16'h0000;
	// byte address, stack grows down from here
	localparam word_t SP_RESET = 16'h01F8;
	localparam word_t PC_STEP = 16'd2;

endpackage

// File: hdl/instr_decoder.sv
module instr_decoder (
	input stack_cpu_pkg::word_t instr,
	output logic is_push,
	output logic is_pop,
	output logic is_alu,
	output logic is_branch,
	output logic is_call,
	output logic is_ret,
	output logic reg_write,
	output logic mem_write,
	output logic flag_write,
	output stack_cpu_pkg::alu_fn_t alu_fn,
	output stack_cpu_pkg::opcode_t cond
);
	import stack_cpu_pkg::*;

	opcode_t opcode;

	assign opcode = opcode_t'(instr[15:12]);
	assign alu_fn = alu_fn_t'(instr[11:10]);

	// branch condition is the opcode itself
	assign cond = opcode;

	always_comb
	begin
		is_push = 1'b0;
		is_pop = 1'b0;
		is_alu = 1'b0;
		is_branch = 1'b0;
		is_call = 1'b0;
		is_ret = 1'b0;
		case (opcode)
			OP_STACK:
			begin
				// bit 10 picks pop over push
				is_push = ~instr[10];
				is_pop = instr[10];
			end
			OP_ALU:
				is_alu = 1'b1;
			OP_BR_ALWAYS, OP_BR_C, OP_BR_NC, OP_BR_Z, OP_BR_NZ,
			OP_BR_V, OP_BR_NV, OP_BR_S, OP_BR_NS:
				is_branch = 1'b1;
			OP_CALL:
				is_call = 1'b1;
			OP_RET:
				is_ret = 1'b1;
			// 13..15 fall through as no-ops
			default:
				;
		endcase
	end

	// pop and alu write back, push and call store
	assign reg_write = is_pop | is_alu;
	assign mem_write = is_push | is_call;
	assign flag_write = is_alu;

endmodule

// File: hdl/register_bank.sv
module register_bank (
	input logic clk,
	input logic reset,
	input logic write_en,
	input stack_cpu_pkg::reg_idx_t index,
	input stack_cpu_pkg::word_t write_data,
	output stack_cpu_pkg::word_t read_data
);
	import stack_cpu_pkg::*;

	word_t regs [NUM_REGS];

	// decoded write
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (write_en)
		begin
			regs[index] <= write_data;
		end
	end

	// same index for read, so a push reads rd
	assign read_data = regs[index];

endmodule

// File: hdl/alu.sv
module alu (
	input stack_cpu_pkg::word_t x,
	input stack_cpu_pkg::word_t y,
	input stack_cpu_pkg::alu_fn_t fn,
	output stack_cpu_pkg::word_t result,
	output logic carry,
	output logic overflow,
	output logic zero,
	output logic sign
);
	import stack_cpu_pkg::*;

	logic [16:0] sum;
	logic [15:0] low_sum;

	assign sum = {1'b0, x} + {1'b0, y};
	// bit 15 here is the carry out of bit 14
	assign low_sum = {1'b0, x[14:0]} + {1'b0, y[14:0]};

	always_comb
	begin
		carry = 1'b0;
		overflow = 1'b0;
		case (fn)
			ALU_ADD:
			begin
				result = sum[15:0];
				carry = sum[16];
				overflow = sum[16] ^ low_sum[15];
			end
			ALU_NEG:
			begin
				result = (~y) + 16'd1;
			end
			ALU_OR:
			begin
				result = x | y;
			end
			default:
			begin
				result = ~y;
			end
		endcase
	end

	assign zero = (result == '0);
	assign sign = result[15];

endmodule

// File: hdl/status_flags.sv
module status_flags (
	input logic clk,
	input logic reset,
	input logic write_en,
	input logic carry_in,
	input logic overflow_in,
	input logic zero_in,
	input logic sign_in,
	input stack_cpu_pkg::opcode_t cond,
	output logic branch_taken
);
	import stack_cpu_pkg::*;

	logic carry_q;
	logic overflow_q;
	logic zero_q;
	logic sign_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			carry_q <= 1'b0;
			overflow_q <= 1'b0;
			zero_q <= 1'b0;
			sign_q <= 1'b0;
		end
		else if (write_en)
		begin
			carry_q <= carry_in;
			overflow_q <= overflow_in;
			zero_q <= zero_in;
			sign_q <= sign_in;
		end
	end

	// flag or its inverse, per condition code
	always_comb
	begin
		case (cond)
			OP_BR_ALWAYS: branch_taken = 1'b1;
			OP_BR_C:      branch_taken = carry_q;
			OP_BR_NC:     branch_taken = ~carry_q;
			OP_BR_Z:      branch_taken = zero_q;
			OP_BR_NZ:     branch_taken = ~zero_q;
			OP_BR_V:      branch_taken = overflow_q;
			OP_BR_NV:     branch_taken = ~overflow_q;
			OP_BR_S:      branch_taken = sign_q;
			OP_BR_NS:     branch_taken = ~sign_q;
			default:      branch_taken = 1'b0;
		endcase
	end

endmodule

// File: hdl/data_memory.sv
module data_memory (
	input logic clk,
	input logic write_en,
	input stack_cpu_pkg::word_t addr,
	input stack_cpu_pkg::word_t write_data,
	output stack_cpu_pkg::word_t read_data
);
	import stack_cpu_pkg::*;

	word_t mem [DMEM_WORDS];
	logic [DMEM_AW-1:0] word_addr;

	// byte address in, bit 0 dropped
	assign word_addr = addr[DMEM_AW:1];

	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			mem[word_addr] <= write_data;
		end
	end

	assign read_data = mem[word_addr];

endmodule

// File: hdl/instr_memory.sv
module instr_memory (
	input logic clk,
	input logic load_valid,
	input logic load_ready,
	input logic [stack_cpu_pkg::IMEM_AW-1:0] load_addr,
	input stack_cpu_pkg::word_t load_data,
	input stack_cpu_pkg::word_t fetch_addr,
	output stack_cpu_pkg::word_t instr
);
	import stack_cpu_pkg::*;

	word_t mem [IMEM_WORDS];

	// load_addr is already a word index
	always_ff @(posedge clk)
	begin
		if (load_valid && load_ready)
		begin
			mem[load_addr] <= load_data;
		end
	end

	// fetch side is a byte address
	assign instr = mem[fetch_addr[IMEM_AW:1]];

endmodule

// File: hdl/stack_cpu.sv
module stack_cpu (
	input logic clk,
	input logic reset,
	input logic run,
	input logic load_valid,
	input logic [stack_cpu_pkg::IMEM_AW-1:0] load_addr,
	input stack_cpu_pkg::word_t load_data,
	output logic load_ready,
	output stack_cpu_pkg::word_t pc,
	output stack_cpu_pkg::word_t instr,
	output logic wb_valid,
	output stack_cpu_pkg::reg_idx_t wb_reg,
	output stack_cpu_pkg::word_t wb_data,
	output logic mem_write,
	output stack_cpu_pkg::word_t mem_addr,
	output stack_cpu_pkg::word_t mem_data
);
	import stack_cpu_pkg::*;

	word_t sp;
	word_t pc_next;
	word_t sp_next;
	word_t pc_plus;
	word_t target;
	word_t sp_dec;
	word_t sp_inc;
	word_t rd_data;
	word_t pop_data;
	word_t alu_result;

	logic is_push;
	logic is_pop;
	logic is_alu;
	logic is_branch;
	logic is_call;
	logic is_ret;
	logic dec_reg_write;
	logic dec_mem_write;
	logic flag_write;
	logic flag_we;
	alu_fn_t alu_fn;
	opcode_t cond;
	logic branch_taken;

	logic alu_carry;
	logic alu_overflow;
	logic alu_zero;
	logic alu_sign;

	assign load_ready = ~run;

	//////////////////////////////////////////////////////////////////////
	// pc and sp
	//////////////////////////////////////////////////////////////////////

	assign pc_plus = pc + PC_STEP;
	// 12-bit signed offset from pc+2
	assign target = pc_plus + {{4{instr[11]}}, instr[11:0]};
	assign sp_dec = sp - PC_STEP;
	assign sp_inc = sp + PC_STEP;

	always_comb
	begin
		if (!run)
			pc_next = pc;
		else if (is_ret)
			pc_next = pop_data;
		else if (is_call || (is_branch && branch_taken))
			pc_next = target;
		else
			pc_next = pc_plus;
	end

	always_comb
	begin
		sp_next = sp;
		if (run)
		begin
			if (is_push || is_call)
				sp_next = sp_dec;
			else if (is_pop || is_ret)
				sp_next = sp_inc;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pc <= PC_RESET;
			sp <= SP_RESET;
		end
		else
		begin
			pc <= pc_next;
			sp <= sp_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// operand muxes and trace
	//////////////////////////////////////////////////////////////////////

	// stores go below sp, loads come from sp
	assign mem_addr = dec_mem_write ? sp_dec : sp;
	assign mem_data = is_call ? pc_plus : rd_data;
	assign mem_write = dec_mem_write & run;

	assign wb_valid = dec_reg_write & run;
	assign wb_reg = instr[9:7];
	assign wb_data = is_alu ? alu_result : pop_data;

	assign flag_we = flag_write & run;

	instr_memory u_imem (
		.clk        (clk),
		.load_valid (load_valid),
		.load_ready (load_ready),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.fetch_addr (pc),
		.instr      (instr)
	);

	instr_decoder u_decoder (
		.instr      (instr),
		.is_push    (is_push),
		.is_pop     (is_pop),
		.is_alu     (is_alu),
		.is_branch  (is_branch),
		.is_call    (is_call),
		.is_ret     (is_ret),
		.reg_write  (dec_reg_write),
		.mem_write  (dec_mem_write),
		.flag_write (flag_write),
		.alu_fn     (alu_fn),
		.cond       (cond)
	);

	register_bank u_regs (
		.clk        (clk),
		.reset      (reset),
		.write_en   (wb_valid),
		.index      (wb_reg),
		.write_data (wb_data),
		.read_data  (rd_data)
	);

	// y is the word on top of the stack
	alu u_alu (
		.x        (rd_data),
		.y        (pop_data),
		.fn       (alu_fn),
		.result   (alu_result),
		.carry    (alu_carry),
		.overflow (alu_overflow),
		.zero     (alu_zero),
		.sign     (alu_sign)
	);

	status_flags u_flags (
		.clk          (clk),
		.reset        (reset),
		.write_en     (flag_we),
		.carry_in     (alu_carry),
		.overflow_in  (alu_overflow),
		.zero_in      (alu_zero),
		.sign_in      (alu_sign),
		.cond         (cond),
		.branch_taken (branch_taken)
	);

	data_memory u_dmem (
		.clk        (clk),
		.write_en   (mem_write),
		.addr       (mem_addr),
		.write_data (mem_data),
		.read_data  (pop_data)
	);

endmodule

// File: verification/stack_cpu_asserts.sv
module stack_cpu_asserts (
	input logic clk,
	input logic reset,
	input logic run,
	input logic load_ready,
	input stack_cpu_pkg::word_t pc,
	input stack_cpu_pkg::word_t instr,
	input logic wb_valid,
	input stack_cpu_pkg::reg_idx_t wb_reg,
	input stack_cpu_pkg::word_t wb_data,
	input logic mem_write,
	input stack_cpu_pkg::word_t mem_addr,
	input stack_cpu_pkg::word_t mem_data
);
	timeunit 1ns;
	timeprecision 1ps;
	import stack_cpu_pkg::*;

	int error_count = 0;

	opcode_t op;
	logic is_push;
	logic is_pop;
	logic is_alu;
	logic is_ret;
	logic zs_branch;
	logic cond_met;
	word_t pc_plus;
	word_t target;
	word_t branch_next;

	// shadow state
	word_t shadow_regs [8];
	logic prev_push;
	word_t prev_push_data;
	logic seen_stack;
	logic zero_f;
	logic sign_f;
	logic call_open;
	word_t ret_addr;
	int depth;

	function automatic word_t alu_model(input alu_fn_t fn, input word_t x, input word_t y);
		case (fn)
			ALU_ADD: return x + y;
			ALU_NEG: return 16'd0 - y;
			ALU_OR: return x | y;
			default: return ~y;
		endcase
	endfunction

	assign op = opcode_t'(instr[15:12]);
	assign is_push = (op == OP_STACK) && !instr[10];
	assign is_pop = (op == OP_STACK) && instr[10];
	assign is_alu = (op == OP_ALU);
	assign is_ret = (op == OP_RET);
	assign zs_branch = op inside {OP_BR_Z, OP_BR_NZ, OP_BR_S, OP_BR_NS};
	assign pc_plus = pc + 16'd2;
	assign target = pc_plus + {{4{instr[11]}}, instr[11:0]};
	assign branch_next = cond_met ? target : pc_plus;

	always_comb
	begin
		case (op)
			OP_BR_Z: cond_met = zero_f;
			OP_BR_NZ: cond_met = !zero_f;
			OP_BR_S: cond_met = sign_f;
			default: cond_met = !sign_f;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
			begin
				shadow_regs[i] <= '0;
			end
			prev_push <= 1'b0;
			prev_push_data <= '0;
			seen_stack <= 1'b0;
			zero_f <= 1'b0;
			sign_f <= 1'b0;
			call_open <= 1'b0;
			ret_addr <= '0;
			depth <= 0;
		end
		else if (run)
		begin
			prev_push <= is_push;
			if (is_push)
				prev_push_data <= mem_data;
			if (op == OP_STACK || op == OP_CALL || is_ret)
				seen_stack <= 1'b1;
			if (wb_valid)
				shadow_regs[wb_reg] <= wb_data;
			if (is_alu)
			begin
				zero_f <= (wb_data == '0);
				sign_f <= wb_data[15];
			end
			// depth counts pushes since the last call
			if (op == OP_CALL)
			begin
				call_open <= 1'b1;
				ret_addr <= pc_plus;
				depth <= 0;
			end
			else if (is_push)
				depth <= depth + 1;
			else if (is_pop)
				depth <= depth - 1;
			else if (is_ret)
				call_open <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reset and load port
	//////////////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk)
		(reset || $past(reset)) |-> pc == PC_RESET && !wb_valid && !mem_write)
		else begin $error("pc or trace not idle around reset"); error_count++; end

	a_first_push: assert property (@(posedge clk) disable iff (reset)
		run && is_push && !seen_stack |-> mem_addr == SP_RESET - 16'd2)
		else begin $error("first push at wrong address"); error_count++; end

	a_load_blocked: assert property (@(posedge clk) disable iff (reset)
		run |-> !load_ready)
		else begin $error("load_ready high while running"); error_count++; end

	//////////////////////////////////////////////////////////////////////
	// next pc
	//////////////////////////////////////////////////////////////////////

	a_seq_pc: assert property (@(posedge clk) disable iff (reset)
		run && (op == OP_STACK || op == OP_ALU || op > OP_RET) |=> pc == $past(pc_plus))
		else begin $error("pc did not step by two"); error_count++; end

	a_jump_pc: assert property (@(posedge clk) disable iff (reset)
		run && (op == OP_BR_ALWAYS || op == OP_CALL) |=> pc == $past(target))
		else begin $error("jump or call went to wrong target"); error_count++; end

	a_cond_branch: assert property (@(posedge clk) disable iff (reset)
		run && zs_branch |=> pc == $past(branch_next))
		else begin $error("zero or sign branch decided wrongly"); error_count++; end

	//////////////////////////////////////////////////////////////////////
	// stack and alu
	//////////////////////////////////////////////////////////////////////

	a_push_pop: assert property (@(posedge clk) disable iff (reset)
		run && is_pop && prev_push
		|-> wb_valid && wb_reg == instr[9:7] && wb_data == prev_push_data)
		else begin $error("pop did not return pushed word"); error_count++; end

	a_call_store: assert property (@(posedge clk) disable iff (reset)
		run && op == OP_CALL |-> mem_write && mem_data == pc_plus)
		else begin $error("call stored wrong return address"); error_count++; end

	a_ret_pc: assert property (@(posedge clk) disable iff (reset)
		run && is_ret && call_open && depth == 0 |=> pc == $past(ret_addr))
		else begin $error("return went to wrong address"); error_count++; end

	a_alu_result: assert property (@(posedge clk) disable iff (reset)
		run && is_alu && prev_push |-> wb_valid && wb_data == alu_model(
			alu_fn_t'(instr[11:10]), shadow_regs[instr[9:7]], prev_push_data))
		else begin $error("alu result wrong"); error_count++; end

endmodule

// File: verification/stack_cpu_tb.sv
module stack_cpu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import stack_cpu_pkg::*;

	localparam int LOAD_TIMEOUT = 20;
	localparam int RUN_TIMEOUT = 200;
	// byte address of the branch-to-self after the call
	localparam word_t HALT_PC = 16'd44;

	logic clk;
	logic reset;
	logic run;
	logic load_valid;
	logic [IMEM_AW-1:0] load_addr;
	word_t load_data;
	logic load_ready;
	word_t pc;
	word_t instr;
	logic wb_valid;
	reg_idx_t wb_reg;
	word_t wb_data;
	logic mem_write;
	word_t mem_addr;
	word_t mem_data;

	word_t loaded [IMEM_WORDS];
	int tb_errors;
	logic timed_out;

	stack_cpu DUT (.*);

	bind stack_cpu stack_cpu_asserts u_asserts (.*);

	always #2 clk = ~clk;

	function automatic word_t enc_stack(input logic pop, input reg_idx_t rd);
		return {OP_STACK, 1'b0, pop, rd, 7'd0};
	endfunction

	function automatic word_t enc_alu(input alu_fn_t fn, input reg_idx_t rd);
		return {OP_ALU, fn, rd, 7'd0};
	endfunction

	function automatic word_t enc_jump(input opcode_t op, input logic [11:0] offset);
		return {op, offset};
	endfunction

	task automatic build_program();
		// nop fill, also covers the skipped slots 7, 12 and 23
		for (int i = 0; i < IMEM_WORDS; i++)
			loaded[i] = {4'(13 + $urandom_range(0, 2)), 4'($urandom), 8'(i)};
		loaded[0] = enc_stack(1'b0, 3'd0);
		loaded[1] = enc_alu(ALU_NOT, 3'd1);
		loaded[2] = enc_stack(1'b0, 3'd1);
		loaded[3] = enc_alu(ALU_NEG, 3'd2);
		loaded[4] = enc_stack(1'b0, 3'd2);
		// ffff + 1 wraps to zero
		loaded[5] = enc_alu(ALU_ADD, 3'd1);
		loaded[6] = enc_jump(OP_BR_Z, 12'd2);
		loaded[8] = enc_jump(OP_BR_NZ, 12'd2);
		loaded[9] = enc_stack(1'b0, 3'd2);
		loaded[10] = enc_alu(ALU_NEG, 3'd4);
		loaded[11] = enc_jump(OP_BR_S, 12'd2);
		loaded[13] = enc_jump(OP_BR_NS, 12'd2);
		loaded[14] = enc_stack(1'b1, 3'd6);
		loaded[15] = enc_stack(1'b0, 3'd4);
		loaded[16] = enc_stack(1'b1, 3'd7);
		loaded[17] = enc_stack(1'b0, 3'd2);
		loaded[18] = enc_alu(ALU_ADD, 3'd2);
		loaded[19] = enc_stack(1'b0, 3'd6);
		loaded[20] = enc_alu(ALU_OR, 3'd2);
		loaded[21] = enc_jump(OP_CALL, 12'd4);
		loaded[22] = enc_jump(OP_BR_ALWAYS, 12'hFFE);
		// subroutine with a balanced push and pop
		loaded[24] = enc_stack(1'b0, 3'd2);
		loaded[25] = enc_stack(1'b1, 3'd3);
		loaded[26] = {OP_RET, 12'd0};
	endtask

	task automatic load_word(input int idx);
		int waited;
		waited = 0;
		repeat ($urandom_range(0, 2))
		begin
			@(posedge clk);
			#1;
		end
		load_valid = 1'b1;
		load_addr = IMEM_AW'(idx);
		load_data = loaded[idx];
		while (!load_ready && waited < LOAD_TIMEOUT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!load_ready)
		begin
			$display("load_ready stayed low for %0d cycles at word %0d", LOAD_TIMEOUT, idx);
			tb_errors++;
			timed_out = 1'b1;
		end
		else
		begin
			@(posedge clk);
			#1;
		end
		load_valid = 1'b0;
	endtask

	task automatic check_fetch();
		if (instr !== loaded[pc[IMEM_AW:1]])
		begin
			$display("mismatch fetch: pc %h expected %h actual %h",
				pc, loaded[pc[IMEM_AW:1]], instr);
			tb_errors++;
		end
	endtask

	task automatic run_program();
		int cycles;
		cycles = 0;
		run = 1'b1;
		while (pc != HALT_PC && cycles < RUN_TIMEOUT)
		begin
			check_fetch();
			@(posedge clk);
			#1;
			cycles++;
		end
		if (pc != HALT_PC)
		begin
			$display("program did not reach the halt loop within %0d cycles", RUN_TIMEOUT);
			tb_errors++;
		end
		// a few laps around the halt loop
		repeat (4)
		begin
			check_fetch();
			@(posedge clk);
			#1;
		end
		run = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h36429029));
		clk = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		tb_errors = 0;
		timed_out = 1'b0;
		build_program();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < IMEM_WORDS && !timed_out; i++)
			load_word(i);
		if (!timed_out)
			run_program();
		@(posedge clk);
		#1;
		$display("errors: %0d assertion, %0d testbench",
			DUT.u_asserts.error_count, tb_errors);
		if (DUT.u_asserts.error_count == 0 && tb_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: stack_cpu.f
hdl/stack_cpu_pkg.sv
hdl/instr_decoder.sv
hdl/register_bank.sv
hdl/alu.sv
hdl/status_flags.sv
hdl/data_memory.sv
hdl/instr_memory.sv
hdl/stack_cpu.sv
verification/stack_cpu_asserts.sv
verification/stack_cpu_tb.sv

// File: Makefile
TOP ?= stack_cpu_tb
FILELIST ?= stack_cpu.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
RUN_ARGS ?= +verilator+error+limit+1000

FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
